// File: Makefile
# Verilator build and run of the MCU SRAM controller testbench
TOP := mcu_sram_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

# Passes only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: design/access_sequencer.sv
// One request in flight; the requester holds the request stable while hold is high
// Reads and partial writes take two cycles, full writes one
`timescale 1ns/1ns

module access_sequencer (
    input  logic                    clk,
    input  logic                    mci_pwrgood,
    input  logic                    grant,
    input  logic                    deny,
    input  mcu_sram_pkg::cif_req_t  cif_req,
    output mcu_sram_pkg::cif_resp_t cif_resp,
    output mcu_sram_pkg::sram_req_t sram_req,
    input  mcu_sram_pkg::ecc_word_t sram_rdata,
    output logic                    single_ecc_error,
    output logic                    double_ecc_error
);
    import mcu_sram_pkg::*;

    // Request class and phase
    access_kind_e kind;
    logic         second_cycle;

    // SRAM strobes
    logic rd_req;
    logic wr_req;
    logic cs;

    // Data paths
    logic [DATA_W-1:0] rdata_cor;
    logic [DATA_W-1:0] rmw_wdata;
    logic [DATA_W-1:0] wr_data;
    logic [ECC_W-1:0]  wr_ecc;

    ////////////////////
    // Classification
    ////////////////////
    // Partial strobes need the old word first
    always_comb begin
        kind = ACC_NONE;
        if (grant) begin
            if (!cif_req.write) begin
                kind = ACC_READ;
            end else if (&cif_req.wstrb) begin
                kind = ACC_WRITE;
            end else begin
                kind = ACC_RMW;
            end
        end
    end

    ////////////////////
    // SRAM control
    ////////////////////
    // First cycle read, for plain reads and the read phase of RMW
    assign rd_req = ~second_cycle & ((kind == ACC_READ) | (kind == ACC_RMW));

    // Full write goes out at once; RMW write only if the old word was usable
    assign wr_req = (~second_cycle & (kind == ACC_WRITE)) |
                    (second_cycle & (kind == ACC_RMW) & ~double_ecc_error);

    assign cs = rd_req | wr_req;

    // A read always leads to exactly one data cycle
    always_ff @(posedge clk or negedge mci_pwrgood) begin
        if (!mci_pwrgood) begin
            second_cycle <= 1'b0;
        end else begin
            second_cycle <= rd_req;
        end
    end

    ////////////////////
    // Write data
    ////////////////////
    // New bytes where strobed, corrected old bytes elsewhere
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            rmw_wdata[i*8 +: 8] = cif_req.wstrb[i] ? cif_req.wdata[i*8 +: 8]
                                                   : rdata_cor[i*8 +: 8];
        end
    end

    assign wr_data = !wr_req             ? '0 :
                     (kind == ACC_RMW)   ? rmw_wdata :
                                           cif_req.wdata;

    secded_encode u_encode (
        .data (wr_data),
        .ecc  (wr_ecc)
    );

    // Word address drops the byte offset
    assign sram_req = '{cs:    cs,
                        we:    wr_req,
                        addr:  cs ? cif_req.addr[CIF_ADDR_W-1:2] : '0,
                        wdata: '{data: wr_data, ecc: wr_ecc}};

    ////////////////////
    // Read data and response
    ////////////////////
    // Decode only in the cycle the SRAM data is valid
    secded_decode u_decode (
        .en         (second_cycle),
        .code       (sram_rdata),
        .data       (rdata_cor),
        .single_err (single_ecc_error),
        .double_err (double_ecc_error)
    );

    // Hold spans the first read cycle only
    // RMW read data stays internal
    assign cif_resp = '{hold:  rd_req,
                        error: deny | double_ecc_error,
                        rdata: (second_cycle && (kind == ACC_READ)) ? rdata_cor : '0};

endmodule

// File: design/mcu_sram_ctrl.sv
// Fabric to MCU SRAM controller with region filtering and SECDED protection
// The SRAM must return read data one cycle after a read with cs high
`timescale 1ns/1ns

module mcu_sram_ctrl (
    input  logic                                   clk,
    input  logic                                   mci_pwrgood,
    input  logic                                   mcu_rst_b,
    input  logic [mcu_sram_pkg::REGION_SIZE_W-1:0] fw_exec_region_size,
    input  logic                                   exec_region_lock,
    input  logic                                   dv,
    input  mcu_sram_pkg::cif_req_t                 cif_req,
    input  mcu_sram_pkg::access_priv_t             priv,
    output mcu_sram_pkg::cif_resp_t                cif_resp,
    output mcu_sram_pkg::sram_req_t                sram_req,
    input  mcu_sram_pkg::ecc_word_t                sram_rdata,
    output logic                                   sram_single_ecc_error,
    output logic                                   sram_double_ecc_error
);
    import mcu_sram_pkg::*;

    // Filter verdict, already qualified by dv
    logic grant;
    logic deny;

    // Address bits inside the SRAM scope; upper bits are routed by the fabric
    region_filter u_region_filter (
        .clk                 (clk),
        .mci_pwrgood         (mci_pwrgood),
        .mcu_rst_b           (mcu_rst_b),
        .exec_region_lock    (exec_region_lock),
        .fw_exec_region_size (fw_exec_region_size),
        .dv                  (dv),
        .addr                (cif_req.addr[CIF_ADDR_W-1:0]),
        .priv                (priv),
        .grant               (grant),
        .deny                (deny)
    );

    // Owns the second cycle, the SRAM strobes and the response
    access_sequencer u_access_sequencer (
        .clk              (clk),
        .mci_pwrgood      (mci_pwrgood),
        .grant            (grant),
        .deny             (deny),
        .cif_req          (cif_req),
        .cif_resp         (cif_resp),
        .sram_req         (sram_req),
        .sram_rdata       (sram_rdata),
        .single_ecc_error (sram_single_ecc_error),
        .double_ecc_error (sram_double_ecc_error)
    );

endmodule

// File: design/mcu_sram_pkg.sv
// SRAM geometry is fixed here; the SECDED code only covers a 32-bit word
// Region size is in 4 KB steps, with 0 meaning one 4 KB step
package mcu_sram_pkg;

    ////////////////////
    // Geometry
    ////////////////////
    localparam int SRAM_SIZE_KB      = 16;
    localparam int DATA_W            = 32;
    localparam int ECC_W             = 7;
    localparam int CODE_W            = DATA_W + ECC_W;
    localparam int STRB_W            = DATA_W / 8;
    localparam int SRAM_SIZE_BYTES   = SRAM_SIZE_KB * 1024;
    // Byte address bits that reach the SRAM
    localparam int CIF_ADDR_W        = $clog2(SRAM_SIZE_BYTES);
    localparam int SRAM_ADDR_W       = CIF_ADDR_W - 2;
    localparam int REGION_STEP_SHIFT = 12;
    localparam int REGION_SIZE_W     = 16;
    // Size field plus one, shifted by 12, needs 29 bits
    localparam int REGION_CALC_W     = REGION_SIZE_W + REGION_STEP_SHIFT + 1;

    ////////////////////
    // Bus types
    ////////////////////
    // One stored SRAM word
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ECC_W-1:0]  ecc;
    } ecc_word_t;

    typedef struct packed {
        logic [31:0]       addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } cif_req_t;

    typedef struct packed {
        logic              hold;
        logic              error;
        logic [DATA_W-1:0] rdata;
    } cif_resp_t;

    // Qualifiers of the current request
    typedef struct packed {
        logic lsu;
        logic ifu;
        logic sram_config;
        logic debug;
    } access_priv_t;

    typedef struct packed {
        logic                   cs;
        logic                   we;
        logic [SRAM_ADDR_W-1:0] addr;
        ecc_word_t              wdata;
    } sram_req_t;

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_READ,
        ACC_WRITE,
        ACC_RMW
    } access_kind_e;

    // Hamming position of data bit idx; skips powers of two, which hold check bits
    function automatic int unsigned ecc_pos(input int unsigned idx);
        int unsigned pos;
        int unsigned cnt;
        pos = 0;
        cnt = 0;
        for (int unsigned p = 3; p < CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    pos = p;
                end
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

// File: design/region_filter.sv
// Exec region starts at 0; a size past the end of the SRAM makes it all exec
// grant and deny are qualified by dv and never high together
`timescale 1ns/1ns

module region_filter (
    input  logic                                   clk,
    input  logic                                   mci_pwrgood,
    input  logic                                   mcu_rst_b,
    input  logic                                   exec_region_lock,
    input  logic [mcu_sram_pkg::REGION_SIZE_W-1:0] fw_exec_region_size,
    input  logic                                   dv,
    input  logic [mcu_sram_pkg::CIF_ADDR_W-1:0]    addr,
    input  mcu_sram_pkg::access_priv_t             priv,
    output logic                                   grant,
    output logic                                   deny
);
    import mcu_sram_pkg::*;

    // Region bound arithmetic
    logic [REGION_CALC_W-1:0] exec_size_bytes;
    logic [REGION_CALC_W-1:0] exec_end_calc;
    logic [REGION_CALC_W-1:0] exec_end;
    logic                     exec_overflow;

    // Region decode and ownership
    logic exec_match;
    logic mcu_owned;

    // Per region access verdicts
    logic exec_ok;
    logic prot_ok;
    logic access_ok;

    ////////////////////
    // Exec region bound
    ////////////////////
    // Widen before adding one so size 0xFFFF does not wrap
    assign exec_size_bytes = (REGION_CALC_W'(fw_exec_region_size) + 1'b1) << REGION_STEP_SHIFT;
    assign exec_end_calc   = exec_size_bytes - 1'b1;

    // Any bit above the SRAM scope means the region covers the whole SRAM
    assign exec_overflow = |exec_end_calc[REGION_CALC_W-1:CIF_ADDR_W];
    assign exec_end      = exec_overflow ? REGION_CALC_W'(SRAM_SIZE_BYTES - 1) : exec_end_calc;

    // Lower part is exec, the rest is prot
    assign exec_match = (addr <= exec_end[CIF_ADDR_W-1:0]);

    ////////////////////
    // Ownership flag
    ////////////////////
    // MCU may still fetch from the exec region after the lock drops
    // Hand the region back only once the MCU sits in reset
    always_ff @(posedge clk or negedge mci_pwrgood) begin
        if (!mci_pwrgood) begin
            mcu_owned <= 1'b0;
        end else if (exec_region_lock) begin
            mcu_owned <= 1'b1;
        end else if (!mcu_rst_b) begin
            mcu_owned <= 1'b0;
        end
    end

    ////////////////////
    // Privilege rules
    ////////////////////
    // Debug mode opens both regions
    // MCU owned exec region takes LSU or IFU; otherwise only config requests
    assign exec_ok = mcu_owned ? (priv.lsu | priv.ifu | priv.debug)
                               : (priv.sram_config | priv.debug);

    // Prot region is data only for the MCU
    assign prot_ok = priv.lsu | priv.debug;

    assign access_ok = exec_match ? exec_ok : prot_ok;

    // Deny answers in the dv cycle, before anything reaches the SRAM
    assign grant = dv & access_ok;
    assign deny  = dv & ~access_ok;

endmodule

// File: design/secded_decode.sv
// Combinational SECDED decoder; corrects one data bit, detects two flipped bits
// Flags are gated by en, correction is not
`timescale 1ns/1ns

module secded_decode (
    input  logic                            en,
    input  mcu_sram_pkg::ecc_word_t         code,
    output logic [mcu_sram_pkg::DATA_W-1:0] data,
    output logic                            single_err,
    output logic                            double_err
);
    import mcu_sram_pkg::*;

    // Points at the flipped position when one bit is bad
    logic [ECC_W-2:0] syndrome;
    // Odd number of flipped bits across the whole word
    logic             parity_err;

    ////////////////////
    // Syndrome
    ////////////////////
    always_comb begin
        int unsigned pos;
        // Start from the stored check bits, fold in recomputed parity
        syndrome = code.ecc[ECC_W-2:0];
        for (int i = 0; i < DATA_W; i++) begin
            pos = ecc_pos(i);
            for (int b = 0; b < ECC_W - 1; b++) begin
                if (pos[b]) begin
                    syndrome[b] = syndrome[b] ^ code.data[i];
                end
            end
        end
    end

    assign parity_err = ^{code.data, code.ecc};

    ////////////////////
    // Correction
    ////////////////////
    always_comb begin
        int unsigned pos;
        data = code.data;
        for (int i = 0; i < DATA_W; i++) begin
            pos = ecc_pos(i);
            // Only with odd parity; an even count means two flips, uncorrectable
            if (parity_err && (syndrome == pos[ECC_W-2:0])) begin
                data[i] = ~code.data[i];
            end
        end
    end

    ////////////////////
    // Error flags
    ////////////////////
    // Odd parity means one flip, possibly in a check bit or the parity bit itself
    assign single_err = en & parity_err;
    // Even parity with a nonzero syndrome means two flips
    assign double_err = en & ~parity_err & (|syndrome);

endmodule

// File: design/secded_encode.sv
// Combinational SECDED encoder for one 32-bit word
// ecc[5:0] are Hamming bits, ecc[6] is overall parity over data and ecc[5:0]
`timescale 1ns/1ns

module secded_encode (
    input  logic [mcu_sram_pkg::DATA_W-1:0] data,
    output logic [mcu_sram_pkg::ECC_W-1:0]  ecc
);
    import mcu_sram_pkg::*;

    // Hamming check bits only
    logic [ECC_W-2:0] hamming;

    ////////////////////
    // Hamming parity
    ////////////////////
    always_comb begin
        int unsigned pos;
        hamming = '0;
        for (int i = 0; i < DATA_W; i++) begin
            // Each data bit feeds every check bit set in its position
            pos = ecc_pos(i);
            for (int b = 0; b < ECC_W - 1; b++) begin
                if (pos[b]) begin
                    hamming[b] = hamming[b] ^ data[i];
                end
            end
        end
    end

    // Overall parity turns SEC into SECDED
    assign ecc = {^{data, hamming}, hamming};

endmodule

// File: files.f
design/mcu_sram_pkg.sv
design/secded_encode.sv
design/secded_decode.sv
design/region_filter.sv
design/access_sequencer.sv
design/mcu_sram_ctrl.sv
tests/mcu_sram_ctrl_assert.sv
tests/mcu_sram_ctrl_tb.sv

// File: tests/mcu_sram_ctrl_assert.sv
// Protocol checks on the controller top, attached by bind
// Checks are off while mci_pwrgood is low
`timescale 1ns/1ns

module mcu_sram_ctrl_assert (
    input logic                    clk,
    input logic                    mci_pwrgood,
    input logic                    dv,
    input mcu_sram_pkg::cif_resp_t cif_resp,
    input mcu_sram_pkg::sram_req_t sram_req
);
    // Set by the first request after reset
    logic dv_seen;

    always_ff @(posedge clk or negedge mci_pwrgood) begin
        if (!mci_pwrgood) begin
            dv_seen <= 1'b0;
        end else if (dv) begin
            dv_seen <= 1'b1;
        end
    end

    ////////////////////
    // SRAM side
    ////////////////////
    a_we_needs_cs: assert property (@(posedge clk) disable iff (!mci_pwrgood)
        sram_req.we |-> sram_req.cs)
        else $error("SRAM write enable without chip select");

    // No SRAM access and no hold between reset and the first request
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!mci_pwrgood)
        !dv_seen && !dv |-> !sram_req.cs && !cif_resp.hold)
        else $error("SRAM chip select or hold before any request");

    ////////////////////
    // Response side
    ////////////////////
    a_hold_one_cycle: assert property (@(posedge clk) disable iff (!mci_pwrgood)
        cif_resp.hold |=> !cif_resp.hold)
        else $error("hold high for two cycles in a row");

    a_quiet_without_dv: assert property (@(posedge clk) disable iff (!mci_pwrgood)
        !dv |-> !cif_resp.error && !sram_req.cs)
        else $error("error or chip select without dv");

endmodule

bind mcu_sram_ctrl mcu_sram_ctrl_assert u_assert (
    .clk         (clk),
    .mci_pwrgood (mci_pwrgood),
    .dv          (dv),
    .cif_resp    (cif_resp),
    .sram_req    (sram_req)
);

// File: tests/mcu_sram_ctrl_tb.sv
// Directed testbench for the MCU SRAM controller with a behavioral SRAM model
// The model stores the DUT's encoded words as they are, so no ECC math lives here
// Bit flips on reads come from inject_mask, which the tests set around one access
`timescale 1ns/1ns

module mcu_sram_ctrl_tb;
    import mcu_sram_pkg::*;

    localparam int          HOLD_TIMEOUT = 8;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam int          WORDS        = 1 << SRAM_ADDR_W;

    // Request qualifier presets
    localparam access_priv_t PRIV_LSU = '{lsu: 1'b1, ifu: 1'b0, sram_config: 1'b0, debug: 1'b0};
    localparam access_priv_t PRIV_IFU = '{lsu: 1'b0, ifu: 1'b1, sram_config: 1'b0, debug: 1'b0};
    localparam access_priv_t PRIV_CFG = '{lsu: 1'b0, ifu: 1'b0, sram_config: 1'b1, debug: 1'b0};
    localparam access_priv_t PRIV_DBG = '{lsu: 1'b0, ifu: 1'b0, sram_config: 1'b0, debug: 1'b1};

    // DUT inputs
    logic                     clk;
    logic                     mci_pwrgood;
    logic                     mcu_rst_b;
    logic [REGION_SIZE_W-1:0] fw_exec_region_size;
    logic                     exec_region_lock;
    logic                     dv;
    cif_req_t                 cif_req;
    access_priv_t             priv;
    ecc_word_t                sram_rdata = '0;

    // DUT outputs
    cif_resp_t cif_resp;
    sram_req_t sram_req;
    logic      sram_single_ecc_error;
    logic      sram_double_ecc_error;

    // SRAM model and expected data
    ecc_word_t         mem [0:WORDS-1];
    logic [DATA_W-1:0] ref_mem [0:WORDS-1];
    logic [CODE_W-1:0] inject_mask;

    // Result of the last access as sampled at falling edges
    cif_resp_t last_resp;
    int        hold_cycles;
    logic      first_cs;
    logic      last_cs;
    logic      last_we;
    logic      last_single;
    logic      last_double;

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    mcu_sram_ctrl UUT (
        .clk                   (clk),
        .mci_pwrgood           (mci_pwrgood),
        .mcu_rst_b             (mcu_rst_b),
        .fw_exec_region_size   (fw_exec_region_size),
        .exec_region_lock      (exec_region_lock),
        .dv                    (dv),
        .cif_req               (cif_req),
        .priv                  (priv),
        .cif_resp              (cif_resp),
        .sram_req              (sram_req),
        .sram_rdata            (sram_rdata),
        .sram_single_ecc_error (sram_single_ecc_error),
        .sram_double_ecc_error (sram_double_ecc_error)
    );

    always #20 clk = ~clk;

    ////////////////////
    // SRAM model
    ////////////////////
    // Empty SRAM reads as all zeros, which is a valid code word
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Read data shows up one cycle after cs, with the injected flips
    always @(posedge clk) begin
        if (sram_req.cs && sram_req.we) begin
            mem[sram_req.addr] <= sram_req.wdata;
        end else if (sram_req.cs) begin
            sram_rdata <= ecc_word_t'(mem[sram_req.addr] ^ inject_mask);
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // New bytes where the strobe is set and old bytes elsewhere
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_data,
                                                input logic [31:0] new_data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_data;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Issues one request and holds it until hold drops
    // The response is taken in the accepting cycle
    task automatic run_access(input logic [31:0] byte_addr, input logic is_write,
                              input logic [31:0] data, input logic [3:0] strb,
                              input access_priv_t p);
        int waited;
        bit done;
        @(posedge clk);
        dv      <= 1'b1;
        cif_req <= '{addr: byte_addr, write: is_write, wdata: data, wstrb: strb};
        priv    <= p;
        hold_cycles = 0;
        waited = 0;
        done = 0;
        @(negedge clk);
        first_cs = sram_req.cs;
        while (!done) begin
            if (!cif_resp.hold) begin
                done = 1;
            end else if (waited >= HOLD_TIMEOUT) begin
                errors++;
                $display("Timeout: hold stayed high for address 0x%0h", byte_addr);
                done = 1;
            end else begin
                hold_cycles++;
                waited++;
                @(negedge clk);
            end
        end
        last_resp   = cif_resp;
        last_cs     = sram_req.cs;
        last_we     = sram_req.we;
        last_single = sram_single_ecc_error;
        last_double = sram_double_ecc_error;
        @(posedge clk);
        dv <= 1'b0;
    endtask

    task automatic write_word(input logic [31:0] a, input logic [31:0] d, input access_priv_t p);
        run_access(a, 1'b1, d, 4'hF, p);
    endtask

    task automatic read_word(input logic [31:0] a, input access_priv_t p);
        run_access(a, 1'b0, 32'h0, 4'h0, p);
    endtask

    // Denied means error in the dv cycle and nothing sent to the SRAM
    task automatic expect_denied();
        check("cif_resp.error", last_resp.error, 1'b1);
        check("sram_req.cs", first_cs, 1'b0);
        check("hold cycles", hold_cycles, 0);
    endtask

    // Reads through debug and compares with the expected word
    task automatic expect_word(input logic [31:0] a);
        read_word(a, PRIV_DBG);
        check("cif_resp.rdata", last_resp.rdata, ref_mem[a[CIF_ADDR_W-1:2]]);
        check("cif_resp.error", last_resp.error, 1'b0);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic test_full_writes();
        logic [31:0] a;
        logic [31:0] d;
        repeat (8) begin
            a = rand_bits(SRAM_ADDR_W) << 2;
            d = rand_bits(32);
            write_word(a, d, PRIV_DBG);
            check("sram_req.cs", first_cs, 1'b1);
            check("hold cycles", hold_cycles, 0);
            ref_mem[a[CIF_ADDR_W-1:2]] = d;
            // Hold only in the first read cycle
            read_word(a, PRIV_DBG);
            check("hold cycles", hold_cycles, 1);
            check("sram_req.cs", first_cs, 1'b1);
            check("cif_resp.rdata", last_resp.rdata, d);
            check("cif_resp.error", last_resp.error, 1'b0);
        end
    endtask

    task automatic test_partial_writes();
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        repeat (6) begin
            a = rand_bits(SRAM_ADDR_W) << 2;
            d = rand_bits(32);
            s = 4'(rand_bits(4));
            // Keep it partial
            if (&s) begin
                s[0] = 1'b0;
            end
            run_access(a, 1'b1, d, s, PRIV_DBG);
            check("hold cycles", hold_cycles, 1);
            check("sram_req.we", last_we, 1'b1);
            check("cif_resp.error", last_resp.error, 1'b0);
            ref_mem[a[CIF_ADDR_W-1:2]] = merge_bytes(ref_mem[a[CIF_ADDR_W-1:2]], d, s);
            expect_word(a);
        end
    endtask

    // With ownership clear and size 0 the exec region is 0x0000 to 0x0FFF
    task automatic test_privilege();
        write_word(32'h0100, 32'hDEAD_0100, PRIV_LSU);
        expect_denied();
        read_word(32'h0100, PRIV_IFU);
        expect_denied();
        expect_word(32'h0100);
        write_word(32'h0100, 32'hC0F1_6000, PRIV_CFG);
        check("cif_resp.error", last_resp.error, 1'b0);
        ref_mem[32'h0100 >> 2] = 32'hC0F1_6000;
        expect_word(32'h0100);
        // Prot region wants LSU or debug
        write_word(32'h2000, 32'hBAD0_2000, PRIV_CFG | PRIV_IFU);
        expect_denied();
        expect_word(32'h2000);
        write_word(32'h2000, 32'h1234_2000, PRIV_LSU);
        check("cif_resp.error", last_resp.error, 1'b0);
        ref_mem[32'h2000 >> 2] = 32'h1234_2000;
        expect_word(32'h2000);
    endtask

    task automatic test_ownership();
        @(posedge clk);
        exec_region_lock <= 1'b1;
        repeat (2) @(posedge clk);
        write_word(32'h0200, 32'h0BAD_C0F1, PRIV_CFG);
        expect_denied();
        write_word(32'h0200, 32'h5A5A_0200, PRIV_LSU);
        check("cif_resp.error", last_resp.error, 1'b0);
        ref_mem[32'h0200 >> 2] = 32'h5A5A_0200;
        read_word(32'h0200, PRIV_IFU);
        check("cif_resp.rdata", last_resp.rdata, 32'h5A5A_0200);
        // Lock low alone keeps the MCU as owner
        @(posedge clk);
        exec_region_lock <= 1'b0;
        repeat (2) @(posedge clk);
        read_word(32'h0200, PRIV_CFG);
        expect_denied();
        @(posedge clk);
        mcu_rst_b <= 1'b0;
        repeat (2) @(posedge clk);
        mcu_rst_b <= 1'b1;
        read_word(32'h0200, PRIV_CFG);
        check("cif_resp.error", last_resp.error, 1'b0);
        check("cif_resp.rdata", last_resp.rdata, 32'h5A5A_0200);
        write_word(32'h0200, 32'h0, PRIV_LSU);
        expect_denied();
    endtask

    task automatic test_region_size();
        read_word(32'h1000, PRIV_CFG);
        expect_denied();
        read_word(32'h1000, PRIV_LSU);
        check("cif_resp.error", last_resp.error, 1'b0);
        // Size 3 covers the whole 16 KB
        @(posedge clk);
        fw_exec_region_size <= 16'd3;
        read_word(32'h1000, PRIV_LSU);
        expect_denied();
        read_word(32'h3FFC, PRIV_CFG);
        check("cif_resp.error", last_resp.error, 1'b0);
        @(posedge clk);
        fw_exec_region_size <= 16'hFFFF;
        read_word(32'h3FFC, PRIV_CFG);
        check("cif_resp.error", last_resp.error, 1'b0);
        read_word(32'h3FFC, PRIV_LSU);
        expect_denied();
        @(posedge clk);
        fw_exec_region_size <= '0;
    endtask

    task automatic test_ecc();
        logic [31:0] a;
        logic [31:0] d;
        int          b;
        a = rand_bits(SRAM_ADDR_W) << 2;
        d = rand_bits(32);
        write_word(a, d, PRIV_DBG);
        ref_mem[a[CIF_ADDR_W-1:2]] = d;
        b = int'(rand_bits(5));
        inject_mask = CODE_W'(1) << b;
        read_word(a, PRIV_DBG);
        check("cif_resp.rdata", last_resp.rdata, d);
        check("sram_single_ecc_error", last_single, 1'b1);
        check("cif_resp.error", last_resp.error, 1'b0);
        // Flags stay low outside the data cycle while a bad word sits on sram_rdata
        write_word(a, d, PRIV_DBG);
        check("sram_single_ecc_error", last_single, 1'b0);
        // Two flips cannot be corrected
        inject_mask = (CODE_W'(1) << b) | (CODE_W'(1) << (b + 3));
        read_word(a, PRIV_DBG);
        check("sram_double_ecc_error", last_double, 1'b1);
        check("cif_resp.error", last_resp.error, 1'b1);
        run_access(a, 1'b1, ~d, 4'b0011, PRIV_DBG);
        check("sram_req.cs", last_cs, 1'b0);
        check("cif_resp.error", last_resp.error, 1'b1);
        inject_mask = '0;
        expect_word(a);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        clk                 = 1'b0;
        mci_pwrgood         = 1'b0;
        mcu_rst_b           = 1'b1;
        fw_exec_region_size = '0;
        exec_region_lock    = 1'b0;
        dv                  = 1'b0;
        cif_req             = '0;
        priv                = '0;
        inject_mask         = '0;
        lfsr                = 32'd26;
        errors              = 0;
        checks              = 0;
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (8) @(posedge clk);
        mci_pwrgood <= 1'b1;
        @(negedge clk);
        check("sram_req.cs", sram_req.cs, 1'b0);
        check("cif_resp.hold", cif_resp.hold, 1'b0);
        check("cif_resp.error", cif_resp.error, 1'b0);
        test_full_writes();
        test_partial_writes();
        test_privilege();
        test_ownership();
        test_region_size();
        test_ecc();
        $display("Checks run: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
